// File: hdl/poolPkg.sv
// Pooling stage shared widths, lane vector type and state/opcode encodings
package poolPkg;

    // ========================================
    // Activation and lane geometry
    // ========================================
    localparam int ACT_WIDTH  = 8;
    localparam int NUM_LANE   = 8;
    localparam int LANE_WIDTH = $clog2(NUM_LANE);
    localparam int ACT_MAX    = 2**ACT_WIDTH - 1;

    typedef logic [ACT_WIDTH-1:0] actT;
    typedef actT [NUM_LANE-1:0] actVecT;

    // ========================================
    // Neighbor count K = 2^kLog
    // ========================================
    localparam int KLOG_WIDTH = 3;
    localparam int KLOG_MIN   = 2;
    localparam int KLOG_MAX   = 4;
    // Word index within one point
    localparam int CNT_WIDTH  = KLOG_MAX;
    // Sum of up to 2^KLOG_MAX activations
    localparam int ACC_WIDTH  = ACT_WIDTH + KLOG_MAX;

    // ========================================
    // Requantization
    // ========================================
    localparam int SCALE_WIDTH = 8;
    localparam int SHIFT_WIDTH = 4;
    localparam int PROD_WIDTH  = ACT_WIDTH + SCALE_WIDTH;

    typedef enum logic {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } poolOpE;

    typedef enum logic [1:0] {
        CORE_IDLE = 2'd0,
        CORE_ACC  = 2'd1,
        CORE_QNT  = 2'd2
    } coreStateE;

endpackage

// File: hdl/poolDistributor.sv
// Pool distributor: holds the configuration, counts words and steers points round-robin
`timescale 1ns/1ps

module poolDistributor #(
    parameter int NUM_CORE = 4
) (
    input  logic                               clk,
    input  logic                               rstN,
    // Configuration strobe
    input  logic                               cfgVld,
    input  poolPkg::poolOpE                    cfgOp,
    input  logic [poolPkg::KLOG_WIDTH-1:0]     cfgKLog,
    input  logic [poolPkg::SCALE_WIDTH-1:0]    cfgScale,
    input  logic [poolPkg::SHIFT_WIDTH-1:0]    cfgShift,
    input  poolPkg::actT                       cfgZp,
    // Word stream
    input  logic                               inStb,
    input  poolPkg::actVecT                    inDat,
    input  logic [NUM_CORE-1:0]                coreBusy,
    // Shared core bus
    output logic [NUM_CORE-1:0]                wordStb,
    output logic                               wordFirst,
    output logic                               wordLast,
    output poolPkg::actVecT                    wordDat,
    output poolPkg::poolOpE                    op,
    output logic [poolPkg::KLOG_WIDTH-1:0]     kLog,
    output logic [poolPkg::SCALE_WIDTH-1:0]    scale,
    output logic [poolPkg::SHIFT_WIDTH-1:0]    shift,
    output poolPkg::actT                       zp,
    output logic                               busy
);
    import poolPkg::*;

    localparam int PTR_WIDTH = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

    logic [CNT_WIDTH-1:0] wordCnt;
    logic [CNT_WIDTH-1:0] lastCnt;
    logic [PTR_WIDTH-1:0] corePtr;
    logic                 midPoint;
    logic                 kLogLegal;
    logic                 cfgAccept;

    // ========================================
    // Configuration acceptance
    // ========================================
    // A word arriving this cycle already makes the point partial
    assign midPoint  = (wordCnt != '0) || inStb;
    assign kLogLegal = (cfgKLog >= KLOG_WIDTH'(KLOG_MIN)) && (cfgKLog <= KLOG_WIDTH'(KLOG_MAX));
    assign cfgAccept = cfgVld && !midPoint && kLogLegal;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            op    <= POOL_MAX;
            kLog  <= KLOG_WIDTH'(KLOG_MIN);
            scale <= SCALE_WIDTH'(1);
            shift <= '0;
            zp    <= '0;
        end else if (cfgAccept) begin
            op    <= cfgOp;
            kLog  <= cfgKLog;
            scale <= cfgScale;
            shift <= cfgShift;
            zp    <= cfgZp;
        end
    end

    // ========================================
    // Word counting and core pointer
    // ========================================
    assign lastCnt   = CNT_WIDTH'((1 << kLog) - 1);
    assign wordFirst = (wordCnt == '0);
    assign wordLast  = (wordCnt == lastCnt);
    assign wordDat   = inDat;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wordCnt <= '0;
            corePtr <= '0;
        end else if (inStb) begin
            if (wordLast) begin
                wordCnt <= '0;
                // Next point goes to the next core
                corePtr <= (corePtr == PTR_WIDTH'(NUM_CORE - 1)) ? '0 : corePtr + 1'b1;
            end else begin
                wordCnt <= wordCnt + 1'b1;
            end
        end
    end

    // One-hot steering of the current word
    always_comb begin
        wordStb = '0;
        if (inStb) begin
            wordStb[corePtr] = 1'b1;
        end
    end

    assign busy = (wordCnt != '0) || (|coreBusy);

endmodule

// File: hdl/poolCore.sv
// Pool core: reduces K neighbor vectors by max or average, then requantizes lane by lane
`timescale 1ns/1ps

module poolCore (
    input  logic                               clk,
    input  logic                               rstN,
    // Word bus from the distributor
    input  logic                               wordStb,
    input  logic                               wordFirst,
    input  logic                               wordLast,
    input  poolPkg::actVecT                    wordDat,
    // Configuration, latched on the first word
    input  poolPkg::poolOpE                    op,
    input  logic [poolPkg::KLOG_WIDTH-1:0]     kLog,
    input  logic [poolPkg::SCALE_WIDTH-1:0]    scale,
    input  logic [poolPkg::SHIFT_WIDTH-1:0]    shift,
    input  poolPkg::actT                       zp,
    // Result side
    output logic                               busy,
    output logic                               doneStb,
    output poolPkg::actVecT                    result
);
    import poolPkg::*;

    coreStateE             state;
    logic [LANE_WIDTH-1:0] laneIdx;

    // Per-point configuration
    poolOpE                 opR;
    logic [KLOG_WIDTH-1:0]  kLogR;
    logic [SCALE_WIDTH-1:0] scaleR;
    logic [SHIFT_WIDTH-1:0] shiftR;
    actT                    zpR;

    logic [ACC_WIDTH-1:0]  acc [NUM_LANE];

    // Requantization datapath
    logic [ACC_WIDTH-1:0]  accSel;
    actT                   pooled;
    logic [PROD_WIDTH-1:0] prod;
    logic [PROD_WIDTH-1:0] prodShift;
    logic [PROD_WIDTH:0]   biased;
    actT                   qntVal;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= CORE_IDLE;
            laneIdx <= '0;
            doneStb <= 1'b0;
        end else begin
            doneStb <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (wordStb && wordFirst) begin
                        state <= wordLast ? CORE_QNT : CORE_ACC;
                    end
                    laneIdx <= '0;
                end
                CORE_ACC: begin
                    if (wordStb && wordLast) begin
                        state <= CORE_QNT;
                    end
                end
                CORE_QNT: begin
                    laneIdx <= laneIdx + 1'b1;
                    if (laneIdx == LANE_WIDTH'(NUM_LANE - 1)) begin
                        state   <= CORE_IDLE;
                        doneStb <= 1'b1;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    assign busy = (state != CORE_IDLE);

    // ========================================
    // Accumulation
    // ========================================
    always_ff @(posedge clk) begin
        if (wordStb && wordFirst) begin
            opR    <= op;
            kLogR  <= kLog;
            scaleR <= scale;
            shiftR <= shift;
            zpR    <= zp;
            // First word seeds both the maximum and the sum
            for (int l = 0; l < NUM_LANE; l++) begin
                acc[l] <= ACC_WIDTH'(wordDat[l]);
            end
        end else if (wordStb && state == CORE_ACC) begin
            for (int l = 0; l < NUM_LANE; l++) begin
                if (opR == POOL_AVG) begin
                    acc[l] <= acc[l] + ACC_WIDTH'(wordDat[l]);
                end else if (ACC_WIDTH'(wordDat[l]) > acc[l]) begin
                    acc[l] <= ACC_WIDTH'(wordDat[l]);
                end
            end
        end
        if (state == CORE_QNT) begin
            result[laneIdx] <= qntVal;
        end
    end

    // ========================================
    // Lane-serial requantization
    // ========================================
    assign accSel    = acc[laneIdx];
    // Average is the sum divided by K
    assign pooled    = (opR == POOL_MAX) ? accSel[ACT_WIDTH-1:0] : actT'(accSel >> kLogR);
    // Single multiplier shared by all lanes
    assign prod      = PROD_WIDTH'(pooled) * PROD_WIDTH'(scaleR);
    assign prodShift = prod >> shiftR;
    assign biased    = {1'b0, prodShift} + (PROD_WIDTH + 1)'(zpR);
    // Saturate to the activation range
    assign qntVal    = (biased > (PROD_WIDTH + 1)'(ACT_MAX)) ? actT'(ACT_MAX)
                                                             : biased[ACT_WIDTH-1:0];

endmodule

// File: hdl/poolCollector.sv
// Pool collector: drains core results in round-robin order onto the output strobe
`timescale 1ns/1ps

module poolCollector #(
    parameter int NUM_CORE = 4
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic [NUM_CORE-1:0] coreDone,
    input  poolPkg::actVecT    coreResult [NUM_CORE],
    output logic               outStb,
    output poolPkg::actVecT    outDat
);
    import poolPkg::*;

    localparam int PTR_WIDTH = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

    logic [PTR_WIDTH-1:0] expPtr;
    logic                 take;

    // Only the core owning the oldest point may be drained
    assign take = coreDone[expPtr];

    // ========================================
    // Order pointer and strobe
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            expPtr <= '0;
            outStb <= 1'b0;
        end else begin
            outStb <= take;
            if (take) begin
                expPtr <= (expPtr == PTR_WIDTH'(NUM_CORE - 1)) ? '0 : expPtr + 1'b1;
            end
        end
    end

    // Output vector register
    always_ff @(posedge clk) begin
        if (take) begin
            outDat <= coreResult[expPtr];
        end
    end

endmodule

// File: hdl/poolTop.sv
// Pooling stage top: distributor, array of pool cores and in-order collector
`timescale 1ns/1ps

module poolTop #(
    parameter int NUM_CORE = 4
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               cfgVld,
    input  poolPkg::poolOpE                    cfgOp,
    input  logic [poolPkg::KLOG_WIDTH-1:0]     cfgKLog,
    input  logic [poolPkg::SCALE_WIDTH-1:0]    cfgScale,
    input  logic [poolPkg::SHIFT_WIDTH-1:0]    cfgShift,
    input  poolPkg::actT                       cfgZp,
    input  logic                               inStb,
    input  poolPkg::actVecT                    inDat,
    output logic                               outStb,
    output poolPkg::actVecT                    outDat,
    output logic                               busy
);
    import poolPkg::*;

    // ========================================
    // Distributor to cores
    // ========================================
    logic [NUM_CORE-1:0]    wordStb;
    logic                   wordFirst;
    logic                   wordLast;
    actVecT                 wordDat;
    poolOpE                 op;
    logic [KLOG_WIDTH-1:0]  kLog;
    logic [SCALE_WIDTH-1:0] scale;
    logic [SHIFT_WIDTH-1:0] shift;
    actT                    zp;

    // Cores to collector
    logic [NUM_CORE-1:0]    coreBusy;
    logic [NUM_CORE-1:0]    coreDone;
    actVecT                 coreResult [NUM_CORE];

    poolDistributor #(
        .NUM_CORE ( NUM_CORE )
    ) uDistributor (
        .clk       ( clk       ),
        .rstN      ( rstN      ),
        .cfgVld    ( cfgVld    ),
        .cfgOp     ( cfgOp     ),
        .cfgKLog   ( cfgKLog   ),
        .cfgScale  ( cfgScale  ),
        .cfgShift  ( cfgShift  ),
        .cfgZp     ( cfgZp     ),
        .inStb     ( inStb     ),
        .inDat     ( inDat     ),
        .coreBusy  ( coreBusy  ),
        .wordStb   ( wordStb   ),
        .wordFirst ( wordFirst ),
        .wordLast  ( wordLast  ),
        .wordDat   ( wordDat   ),
        .op        ( op        ),
        .kLog      ( kLog      ),
        .scale     ( scale     ),
        .shift     ( shift     ),
        .zp        ( zp        ),
        .busy      ( busy      )
    );

    // ========================================
    // Core array
    // ========================================
    for (genvar i = 0; i < NUM_CORE; i++) begin : genCore
        poolCore uCore (
            .clk       ( clk           ),
            .rstN      ( rstN          ),
            .wordStb   ( wordStb[i]    ),
            .wordFirst ( wordFirst     ),
            .wordLast  ( wordLast      ),
            .wordDat   ( wordDat       ),
            .op        ( op            ),
            .kLog      ( kLog          ),
            .scale     ( scale         ),
            .shift     ( shift         ),
            .zp        ( zp            ),
            .busy      ( coreBusy[i]   ),
            .doneStb   ( coreDone[i]   ),
            .result    ( coreResult[i] )
        );
    end

    poolCollector #(
        .NUM_CORE ( NUM_CORE )
    ) uCollector (
        .clk        ( clk        ),
        .rstN       ( rstN       ),
        .coreDone   ( coreDone   ),
        .coreResult ( coreResult ),
        .outStb     ( outStb     ),
        .outDat     ( outDat     )
    );

endmodule

// File: testbench/poolTop_asserts.sv
// Bound checks on core steering, point start and reset behavior of the pooling top
`timescale 1ns/1ps

module poolTop_asserts #(
    parameter int NUM_CORE = 4
) (
    input logic                clk,
    input logic                rstN,
    input logic [NUM_CORE-1:0] wordStb,
    input logic                wordFirst,
    input logic [NUM_CORE-1:0] coreBusy,
    input logic                outStb,
    input logic                busy
);
    // Sticky failure flags, watched by the testbench monitor
    logic steerBad = 1'b0;
    logic startBad = 1'b0;
    logic resetBad = 1'b0;

    // Each word goes to at most one core
    steerOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(wordStb))
    else begin
        steerBad = 1'b1;
        $error("wordStb selects more than one core");
    end

    // A first word never lands on a core still working on an older point
    startIdle: assert property (@(posedge clk) disable iff (!rstN)
        wordFirst |-> ((wordStb & coreBusy) == '0))
    else begin
        startBad = 1'b1;
        $error("point started on a busy core");
    end

    // Quiet outputs once reset has been held for a full cycle
    resetQuiet: assert property (@(posedge clk) (!rstN && $past(!rstN)) |-> (!outStb && !busy))
    else begin
        resetBad = 1'b1;
        $error("outStb or busy high during reset");
    end

endmodule

bind poolTop poolTop_asserts #(
    .NUM_CORE ( NUM_CORE )
) uAsserts (
    .clk       ( clk       ),
    .rstN      ( rstN      ),
    .wordStb   ( wordStb   ),
    .wordFirst ( wordFirst ),
    .coreBusy  ( coreBusy  ),
    .outStb    ( outStb    ),
    .busy      ( busy      )
);

// File: testbench/poolTop_tb.sv
// Pooling stage testbench: random points checked against a behavioral model
`timescale 1ns/1ps

module poolTop_tb;
    import poolPkg::*;

    localparam int NUM_CORE = 4;
    localparam int LATENCY  = NUM_LANE + 2;

    logic                   clk;
    logic                   rstN;
    logic                   cfgVld;
    poolOpE                 cfgOp;
    logic [KLOG_WIDTH-1:0]  cfgKLog;
    logic [SCALE_WIDTH-1:0] cfgScale;
    logic [SHIFT_WIDTH-1:0] cfgShift;
    actT                    cfgZp;
    logic                   inStb;
    actVecT                 inDat;
    logic                   outStb;
    actVecT                 outDat;
    logic                   busy;

    // Model copy of the accepted configuration
    poolOpE mOp    = POOL_MAX;
    int     mKLog  = KLOG_MIN;
    int     mScale = 1;
    int     mShift = 0;
    int     mZp    = 0;
    // Words of the current point and lane-wise running values
    int     mCnt   = 0;
    int     accMax [NUM_LANE];
    int     accSum [NUM_LANE];
    actVecT expQ [$];
    int     lastQ [$];
    int     cycle  = 0;

    poolTop #(.NUM_CORE(NUM_CORE)) UUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic checkVec(string what, actVecT got, actVecT exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkLatency(string what, int got, int exp);
        if (got != exp) begin
            $display("error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic checkFlag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            stopRun();
        end
    endtask

    // ========================================
    // Reference model and stimulus
    // ========================================
    // Scale, shift, zero point, then clamp to 255
    function automatic actT requant(int pooled);
        int v;
        v = ((pooled * mScale) >> mShift) + mZp;
        return (v > ACT_MAX) ? actT'(ACT_MAX) : actT'(v);
    endfunction

    function automatic actVecT randVec();
        actVecT v;
        for (int l = 0; l < NUM_LANE; l++) begin
            v[l] = actT'($urandom);
        end
        return v;
    endfunction

    task automatic idleCycles(int n);
        repeat (n) begin
            @(negedge clk);
            inStb  = 1'b0;
            cfgVld = 1'b0;
        end
    endtask

    // Accepted only between points and with a legal kLog
    task automatic sendCfg(poolOpE op, int kl, int sc, int sh, int z);
        @(negedge clk);
        inStb    = 1'b0;
        cfgVld   = 1'b1;
        cfgOp    = op;
        cfgKLog  = KLOG_WIDTH'(kl);
        cfgScale = SCALE_WIDTH'(sc);
        cfgShift = SHIFT_WIDTH'(sh);
        cfgZp    = actT'(z);
        if (mCnt == 0 && kl >= KLOG_MIN && kl <= KLOG_MAX) begin
            mOp    = op;
            mKLog  = kl;
            mScale = sc;
            mShift = sh;
            mZp    = z;
        end
    endtask

    task automatic sendWord(actVecT v);
        actVecT e;
        @(negedge clk);
        // A partly received point keeps the top busy
        if (mCnt != 0) begin
            checkFlag("busy inside a point", busy, 1'b1);
        end
        cfgVld = 1'b0;
        inStb  = 1'b1;
        inDat  = v;
        for (int l = 0; l < NUM_LANE; l++) begin
            if (mCnt == 0 || int'(v[l]) > accMax[l]) begin
                accMax[l] = int'(v[l]);
            end
            accSum[l] = (mCnt == 0) ? int'(v[l]) : accSum[l] + int'(v[l]);
        end
        mCnt++;
        if (mCnt == (1 << mKLog)) begin
            for (int l = 0; l < NUM_LANE; l++) begin
                e[l] = requant((mOp == POOL_MAX) ? accMax[l] : (accSum[l] >> mKLog));
            end
            expQ.push_back(e);
            // Cycle of the last word, for the latency check
            lastQ.push_back(cycle);
            mCnt = 0;
        end
    endtask

    task automatic sendPoint(int gapMax);
        for (int w = 0; w < (1 << mKLog); w++) begin
            idleCycles($urandom_range(gapMax));
            sendWord(randVec());
        end
    endtask

    task automatic randomCfg(poolOpE op);
        sendCfg(op, $urandom_range(KLOG_MAX, KLOG_MIN), $urandom_range(255),
                $urandom_range(9, 3), $urandom_range(63));
    endtask

    task automatic waitDrained(int limit);
        int n;
        n = 0;
        while (expQ.size() != 0 && n < limit) begin
            idleCycles(1);
            n++;
        end
        if (expQ.size() != 0) begin
            $display("Timeout: %0d results still missing after %0d cycles", expQ.size(), limit);
            stopRun();
        end
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (UUT.uAsserts.steerBad || UUT.uAsserts.startBad || UUT.uAsserts.resetBad) begin
            $display("A bound assertion on the pooling top failed");
            stopRun();
        end else if (outStb && expQ.size() == 0) begin
            $display("An output strobe appeared with no point outstanding");
            stopRun();
        end else if (outStb) begin
            checkVec("outDat", outDat, expQ.pop_front());
            checkLatency("last word to outStb", cycle - lastQ.pop_front(), LATENCY);
        end
    end

    initial begin
        int w;
        void'($urandom(32'hc0c15a8b));
        clk      = 1'b0;
        rstN     = 1'b0;
        cfgVld   = 1'b0;
        cfgOp    = POOL_MAX;
        cfgKLog  = '0;
        cfgScale = '0;
        cfgShift = '0;
        cfgZp    = '0;
        inStb    = 1'b0;
        inDat    = '0;
        repeat (8) @(negedge clk);
        checkFlag("outStb in reset", outStb, 1'b0);
        checkFlag("busy in reset", busy, 1'b0);
        rstN = 1'b1;
        repeat (4) begin
            idleCycles(1);
            checkFlag("busy before the first word", busy, 1'b0);
        end
        // Max pooling, reset configuration first
        sendPoint(2);
        repeat (6) begin
            randomCfg(POOL_MAX);
            repeat (4) sendPoint(2);
        end
        // Average pooling, then saturating settings
        repeat (6) begin
            randomCfg(POOL_AVG);
            repeat (4) sendPoint(2);
        end
        sendCfg(POOL_AVG, 3, 255, 0, 200);
        repeat (3) sendPoint(1);
        // Gapless K=4 points keep every core in flight
        sendCfg(POOL_MAX, KLOG_MIN, 37, 2, 11);
        repeat (16) sendPoint(0);
        // Mid-point and illegal kLog strobes are dropped
        sendCfg(POOL_AVG, 3, 90, 4, 3);
        for (w = 0; w < 8; w++) begin
            if (w == 5) begin
                sendCfg(POOL_MAX, 2, 250, 0, 99);
            end
            sendWord(randVec());
        end
        sendCfg(POOL_MAX, 5, 250, 0, 99);
        sendCfg(POOL_MAX, 1, 250, 0, 99);
        repeat (4) sendPoint(1);
        // Drain, then no stray strobes
        waitDrained(200);
        checkFlag("busy after the last result", busy, 1'b0);
        idleCycles(40);
        checkFlag("busy at the end", busy, 1'b0);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: poolTop.f
hdl/poolPkg.sv
hdl/poolDistributor.sv
hdl/poolCore.sv
hdl/poolCollector.sv
hdl/poolTop.sv
testbench/poolTop_asserts.sv
testbench/poolTop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pooling stage testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
: > sim.log
verilator --binary --timing --assert -Wno-fatal --top-module poolTop_tb \
    -f poolTop.f -o poolSim > build.log 2>&1 \
    && ./obj_dir/poolSim > sim.log 2>&1 \
    || echo "Build or simulation ended abnormally, see build.log and sim.log"
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "FAIL: no pass message"; exit 1; }
echo "PASS"
